// File: design/store_bus_pkg.sv
package store_bus_pkg;

    // ========================================================================
    // bus geometry
    // ========================================================================
    localparam int BUS_DW    = 32;
    localparam int BUS_BYTES = BUS_DW / 8;
    localparam int BUS_ALIGN = 2;
    localparam int BUS_AW    = 32;

    // byte base of the target region
    localparam logic [BUS_AW-1:0] TARGET_ADDR = 32'h1000_0000;

    // bursts and responses in flight
    localparam int NUM_OUTSTANDING = 2;

    // ========================================================================
    // channel payloads
    // ========================================================================

    // write address, len is byte count minus one
    typedef struct packed {
        logic [BUS_AW-1:0] addr;
        logic [31:0]       len;
    } bus_aw_t;

    // one write beat
    typedef struct packed {
        logic [BUS_DW-1:0]    data;
        logic [BUS_BYTES-1:0] strb;
    } bus_w_t;

endpackage

// File: design/store_user_pkg.sv
package store_user_pkg;

    // ========================================================================
    // user side geometry
    // ========================================================================
    localparam int USER_DW    = 16;
    localparam int USER_BYTES = USER_DW / 8;
    localparam int USER_ALIGN = 1;
    localparam int USER_AW    = 32;

    // user words per bus beat
    localparam int PADS       = 2;
    localparam int PAD_BITS   = 1;

    localparam int USER_MAXREQS = 16;
    localparam int WBUFF_DEPTH  = 32;
    localparam int BEAT_LEN_W   = 30;

    // word address and word count
    typedef struct packed {
        logic [USER_AW-1:0] addr;
        logic [31:0]        len;
    } user_req_t;

    typedef struct packed {
        logic [USER_DW-1:0]    data;
        logic [USER_BYTES-1:0] strb;
    } user_w_t;

    // what the packer needs to know about one burst
    typedef struct packed {
        logic [PAD_BITS-1:0]   head;
        logic [PAD_BITS-1:0]   tail;
        logic [BEAT_LEN_W-1:0] last_beat;
    } burst_rec_t;

endpackage

// File: design/store_fifo.sv
module store_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic ACLK,
    input  logic ARESET,
    input  logic wr_en,
    input  T     din,
    output logic full_n,
    input  logic rd_en,
    output T     dout,
    output logic empty_n
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T                mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    assign full_n  = (count != CW'(DEPTH));
    assign empty_n = (count != '0);
    assign do_wr   = wr_en && full_n;
    assign do_rd   = rd_en && empty_n;

    // show-ahead read port
    assign dout = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/store_req_ctrl.sv
module store_req_ctrl
    import store_bus_pkg::*;
    import store_user_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESET,
    // request queue head
    input  user_req_t  req,
    input  logic       req_avail,
    output logic       req_pop,
    // bus address channel
    output bus_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    // burst record queue
    output burst_rec_t burst,
    output logic       burst_push,
    input  logic       burst_room,
    // response type queue
    output logic       rsp_type,
    output logic       rsp_push,
    input  logic       rsp_room
);

    logic              valid_len;
    logic              aw_pend;
    logic              aw_fire;
    logic [BUS_AW-1:0] addr_end;
    logic [31:0]       span;

    // ========================================================================
    // request acceptance
    // ========================================================================

    // zero count or sign bit set means nothing goes to the bus
    assign valid_len = (req.len != 32'd0) && !req.len[31];

    // address waits for a free burst slot
    assign aw_valid = aw_pend && burst_room;
    assign aw_fire  = aw_valid && aw_ready;

    assign req_pop = req_avail && rsp_room && (!aw_pend || aw_fire);

    // every request gets a response slot, valid or not
    assign rsp_push = req_pop;
    assign rsp_type = valid_len;

    always_ff @(posedge ACLK) begin
        if (req_pop) begin
            aw.addr <= TARGET_ADDR + (req.addr << USER_ALIGN);
            aw.len  <= (req.len << USER_ALIGN) - 32'd1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_pend <= 1'b0;
        end else if (req_pop && valid_len) begin
            aw_pend <= 1'b1;
        end else if (aw_fire) begin
            aw_pend <= 1'b0;
        end
    end

    // ========================================================================
    // burst record for the packer
    // ========================================================================

    assign addr_end = aw.addr + aw.len;
    assign span     = aw.len + 32'(aw.addr[BUS_ALIGN-1:0]);

    always_comb begin
        // pad of the first word within its beat
        burst.head      = aw.addr[BUS_ALIGN-1:USER_ALIGN];
        // unused pads above the last word
        burst.tail      = ~addr_end[BUS_ALIGN-1:USER_ALIGN];
        burst.last_beat = span[BUS_ALIGN +: BEAT_LEN_W];
    end

    assign burst_push = aw_fire;

endmodule

// File: design/store_beat_packer.sv
module store_beat_packer
    import store_bus_pkg::*;
    import store_user_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESET,
    // data queue head
    input  user_w_t    wdat,
    input  logic       w_avail,
    output logic       w_pop,
    // burst record queue head
    input  burst_rec_t burst,
    input  logic       burst_avail,
    output logic       burst_pop,
    // bus data channel
    output bus_w_t     w,
    output logic       w_valid_bus,
    input  logic       w_ready_bus
);

    logic [BEAT_LEN_W-1:0] beat_cnt;
    logic                  first_pad;
    logic [PADS-1:0]       pad_oh_q;
    logic [PADS-1:0]       pad_oh;
    logic [PADS-1:0]       head_sel;
    logic [PADS-1:0]       tail_sel;
    logic [PADS-1:0]       zero_lane;
    logic [PAD_BITS-1:0]   tail_idx;
    logic                  ready_for_data;
    logic                  first_beat;
    logic                  last_beat;
    logic                  last_pad;
    logic                  next_pad;
    logic                  next_beat;

    // ========================================================================
    // beat and pad tracking
    // ========================================================================

    // output stage free or draining this cycle
    assign ready_for_data = !w_valid_bus || w_ready_bus;

    assign first_beat = burst_avail && (beat_cnt == '0);
    assign last_beat  = burst_avail && (beat_cnt == burst.last_beat);

    // lane taken by the word at the queue head
    always_comb begin
        if (!w_avail) begin
            pad_oh = '0;
        end else if (first_pad && first_beat) begin
            pad_oh = PADS'(1) << burst.head;
        end else if (first_pad) begin
            pad_oh = PADS'(1);
        end else begin
            pad_oh = pad_oh_q;
        end
    end

    // highest lane in use on the closing beat
    assign tail_idx = PAD_BITS'(PADS - 1) - burst.tail;
    assign last_pad = last_beat ? pad_oh[tail_idx] : pad_oh[PADS-1];

    assign next_pad  = burst_avail && w_avail && ready_for_data;
    assign next_beat = burst_avail && last_pad && ready_for_data;
    assign w_pop     = next_pad;
    assign burst_pop = last_beat && next_beat;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            beat_cnt <= '0;
        end else if (burst_pop) begin
            beat_cnt <= '0;
        end else if (next_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            first_pad <= 1'b1;
            pad_oh_q  <= '0;
        end else if (next_pad) begin
            first_pad <= last_pad;
            pad_oh_q  <= pad_oh << 1;
        end
    end

    // ========================================================================
    // lane fill
    // ========================================================================

    // padding below the head and above the tail
    always_comb begin
        for (int i = 0; i < PADS; i++) begin
            head_sel[i] = first_beat && (i < int'(burst.head));
            tail_sel[i] = last_beat && (i >= PADS - int'(burst.tail));
        end
    end

    assign zero_lane = head_sel | tail_sel;

    always_ff @(posedge ACLK) begin
        for (int i = 0; i < PADS; i++) begin
            if (zero_lane[i] && ready_for_data) begin
                w.data[i*USER_DW +: USER_DW]       <= '0;
                w.strb[i*USER_BYTES +: USER_BYTES] <= '0;
            end else if (pad_oh[i] && next_pad) begin
                w.data[i*USER_DW +: USER_DW]       <= wdat.data;
                w.strb[i*USER_BYTES +: USER_BYTES] <= wdat.strb;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            w_valid_bus <= 1'b0;
        end else if (next_beat) begin
            w_valid_bus <= 1'b1;
        end else if (ready_for_data) begin
            w_valid_bus <= 1'b0;
        end
    end

endmodule

// File: design/store_resp_tracker.sv
module store_resp_tracker (
    input  logic ACLK,
    input  logic ARESET,
    // response type queue head, 1 = bus write issued
    input  logic rsp_type,
    input  logic rsp_avail,
    output logic rsp_pop,
    // bus response channel
    input  logic b_valid_bus,
    output logic b_ready_bus,
    // user completion queue
    output logic cpl_push,
    input  logic cpl_room
);

    logic cpl_ok;
    logic head_done;
    logic cpl_q;

    // ========================================================================
    // in-order completion
    // ========================================================================

    // one completion in flight at a time keeps the room check exact
    assign cpl_ok = cpl_room && !cpl_q;

    // only a bus-backed head entry may take a response
    assign b_ready_bus = rsp_avail && rsp_type && cpl_ok;

    // invalid entries finish on their own
    assign head_done = rsp_avail && cpl_ok && (!rsp_type || b_valid_bus);

    assign rsp_pop = head_done;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            cpl_q <= 1'b0;
        end else begin
            cpl_q <= head_done;
        end
    end

    assign cpl_push = cpl_q;

endmodule

// File: design/axi_store_top.sv
module axi_store_top
    import store_bus_pkg::*;
    import store_user_pkg::*;
(
    input  logic      ACLK,
    input  logic      ARESET,
    // user request, data and completion
    input  user_req_t req,
    input  logic      req_valid,
    output logic      req_ready,
    input  user_w_t   wdat,
    input  logic      w_valid,
    output logic      w_ready,
    output logic      b_valid,
    input  logic      b_ready,
    // bus write channels
    output bus_aw_t   aw,
    output logic      aw_valid,
    input  logic      aw_ready,
    output bus_w_t    w,
    output logic      w_valid_bus,
    input  logic      w_ready_bus,
    input  logic      b_valid_bus,
    output logic      b_ready_bus
);

    user_req_t  req_head;
    logic       req_avail, req_pop;
    user_w_t    wd_head;
    logic       wd_avail, wd_pop;
    burst_rec_t burst_in, burst_out;
    logic       burst_push, burst_room, burst_avail, burst_pop;
    logic       rsp_type_in, rsp_type_out;
    logic       rsp_push, rsp_room, rsp_avail, rsp_pop;
    logic       cpl_push, cpl_room;

    // ========================================================================
    // queues
    // ========================================================================
    store_fifo #(.T(user_req_t), .DEPTH(USER_MAXREQS)) req_q (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_en(req_valid), .din(req), .full_n(req_ready),
        .rd_en(req_pop), .dout(req_head), .empty_n(req_avail)
    );

    store_fifo #(.T(user_w_t), .DEPTH(WBUFF_DEPTH)) dat_q (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_en(w_valid), .din(wdat), .full_n(w_ready),
        .rd_en(wd_pop), .dout(wd_head), .empty_n(wd_avail)
    );

    store_fifo #(.T(burst_rec_t), .DEPTH(NUM_OUTSTANDING)) burst_q (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_en(burst_push), .din(burst_in), .full_n(burst_room),
        .rd_en(burst_pop), .dout(burst_out), .empty_n(burst_avail)
    );

    store_fifo #(.T(logic), .DEPTH(NUM_OUTSTANDING)) rsp_q (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_en(rsp_push), .din(rsp_type_in), .full_n(rsp_room),
        .rd_en(rsp_pop), .dout(rsp_type_out), .empty_n(rsp_avail)
    );

    // completions carry no payload, only occupancy
    store_fifo #(.T(logic), .DEPTH(USER_MAXREQS)) cpl_q (
        .ACLK(ACLK), .ARESET(ARESET),
        .wr_en(cpl_push), .din(1'b1), .full_n(cpl_room),
        .rd_en(b_ready), .dout(), .empty_n(b_valid)
    );

    // ========================================================================
    // datapath
    // ========================================================================
    store_req_ctrl u_req_ctrl (
        .ACLK(ACLK), .ARESET(ARESET),
        .req(req_head), .req_avail(req_avail), .req_pop(req_pop),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .burst(burst_in), .burst_push(burst_push), .burst_room(burst_room),
        .rsp_type(rsp_type_in), .rsp_push(rsp_push), .rsp_room(rsp_room)
    );

    store_beat_packer u_packer (
        .ACLK(ACLK), .ARESET(ARESET),
        .wdat(wd_head), .w_avail(wd_avail), .w_pop(wd_pop),
        .burst(burst_out), .burst_avail(burst_avail), .burst_pop(burst_pop),
        .w(w), .w_valid_bus(w_valid_bus), .w_ready_bus(w_ready_bus)
    );

    store_resp_tracker u_resp (
        .ACLK(ACLK), .ARESET(ARESET),
        .rsp_type(rsp_type_out), .rsp_avail(rsp_avail), .rsp_pop(rsp_pop),
        .b_valid_bus(b_valid_bus), .b_ready_bus(b_ready_bus),
        .cpl_push(cpl_push), .cpl_room(cpl_room)
    );

endmodule

// File: test/store_props.sv
module store_props #(
    parameter int W = 32
) (
    input logic         ACLK,
    input logic         ARESET,
    input logic         valid,
    input logic         ready,
    input logic [W-1:0] payload,
    input logic         rec_avail
);

    int fails = 0;

    // ========================================================================
    // channel stability
    // ========================================================================
    valid_held: assert property (@(posedge ACLK) disable iff (ARESET)
        valid && !ready |=> valid)
    else begin
        fails++;
        $error("valid dropped before ready");
    end

    payload_held: assert property (@(posedge ACLK) disable iff (ARESET)
        valid && !ready |=> $stable(payload))
    else begin
        fails++;
        $error("payload changed while stalled");
    end

    // a channel only opens once its source is queued
    record_first: assert property (@(posedge ACLK) disable iff (ARESET)
        $rose(valid) |-> $past(rec_avail))
    else begin
        fails++;
        $error("valid rose with nothing queued behind it");
    end

endmodule

// File: test/tb_axi_store.sv
module tb_axi_store
    import store_bus_pkg::*;
    import store_user_pkg::*;
();

    localparam int TIMEOUT = 3000;

    logic      ACLK = 1'b0;
    logic      ARESET;
    user_req_t req;
    logic      req_valid, req_ready;
    user_w_t   wdat;
    logic      w_valid, w_ready, b_valid, b_ready;
    bus_aw_t   aw;
    logic      aw_valid, aw_ready;
    bus_w_t    w;
    logic      w_valid_bus, w_ready_bus, b_valid_bus, b_ready_bus;

    integer    seed = 32'hd45d_f51b;
    int        errors = 0;
    int        tests = 0;
    int        cpl_seen = 0;
    int        exp_cpl = 0;
    int        resp_owed = 0;
    int        beat_seen = 0;
    bit        stall_on = 1'b0;
    bit        hold_b = 1'b0;
    user_req_t req_list[$];
    user_w_t   word_list[$];
    bus_aw_t   exp_aw_q[$];
    bus_w_t    exp_w_q[$];
    int        burst_beats[$];

    axi_store_top UUT (.*);

    bind store_req_ctrl store_props #(.W($bits(aw))) aw_chk (
        .ACLK(ACLK), .ARESET(ARESET), .valid(aw_valid), .ready(aw_ready),
        .payload(aw), .rec_avail(req_pop || aw_pend)
    );
    bind store_beat_packer store_props #(.W($bits(w))) w_chk (
        .ACLK(ACLK), .ARESET(ARESET), .valid(w_valid_bus), .ready(w_ready_bus),
        .payload(w), .rec_avail(burst_avail)
    );

    always #50 ACLK = ~ACLK;

    // ========================================================================
    // compare tasks
    // ========================================================================
    task automatic check_aw(input bus_aw_t got, input bus_aw_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: aw addr %h len %h, expected addr %h len %h",
                     $time, got.addr, got.len, exp.addr, exp.len);
            errors++;
        end
    endtask

    task automatic check_w(input bus_w_t got, input bus_w_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: beat %h strb %b, expected %h strb %b",
                     $time, got.data, got.strb, exp.data, exp.strb);
            errors++;
        end
    endtask

    task automatic check_cpl(input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %0d completions, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    // ========================================================================
    // bus slave model
    // ========================================================================
    always @(posedge ACLK) begin
        #1;
        aw_ready    = !stall_on || (($random(seed) & 3) != 0);
        w_ready_bus = !stall_on || (($random(seed) & 3) != 0);
        b_ready     = !stall_on || (($random(seed) & 1) != 0);
        b_valid_bus = (resp_owed > 0) && !hold_b;
    end

    // handshakes sampled mid-cycle complete on the next edge
    always @(negedge ACLK) begin
        bus_aw_t exp_a;
        if (!ARESET) begin
            if (aw_valid && aw_ready) begin
                if (exp_aw_q.size() == 0) begin
                    $display("unexpected bus address %h at %0t", aw.addr, $time);
                    errors++;
                end else begin
                    exp_a = exp_aw_q.pop_front();
                    check_aw(aw, exp_a);
                    burst_beats.push_back(
                        (exp_a.addr % BUS_BYTES + exp_a.len) / BUS_BYTES + 1);
                end
            end
            if (w_valid_bus && w_ready_bus) begin
                if (exp_w_q.size() == 0) begin
                    $display("unexpected bus beat at %0t", $time);
                    errors++;
                end else begin
                    check_w(w, exp_w_q.pop_front());
                end
                beat_seen++;
                if (burst_beats.size() > 0 && beat_seen == burst_beats[0]) begin
                    void'(burst_beats.pop_front());
                    beat_seen = 0;
                    resp_owed++;
                end
            end
            if (b_valid_bus && b_ready_bus) begin
                resp_owed--;
            end
            if (b_valid && b_ready) begin
                cpl_seen++;
            end
        end
    end

    // ========================================================================
    // stimulus and expected values
    // ========================================================================
    task automatic add_request(input logic [31:0] waddr, input logic [31:0] wcnt,
                               input bit full_strb);
        user_req_t r;
        bus_aw_t   a;
        bus_w_t    b;
        user_w_t   u;
        int        lane;
        int        i;
        r.addr = waddr;
        r.len  = wcnt;
        req_list.push_back(r);
        exp_cpl++;
        if (wcnt != 0 && !wcnt[31]) begin
            a.addr = TARGET_ADDR + waddr * USER_BYTES;
            a.len  = wcnt * USER_BYTES - 1;
            exp_aw_q.push_back(a);
            lane = waddr % PADS;
            b    = '0;
            for (i = 0; i < wcnt; i++) begin
                u.data = $random(seed);
                u.strb = full_strb ? 2'b11 : 2'($random(seed));
                word_list.push_back(u);
                b.data[lane*USER_DW +: USER_DW]       = u.data;
                b.strb[lane*USER_BYTES +: USER_BYTES] = u.strb;
                lane++;
                if (lane == PADS) begin
                    exp_w_q.push_back(b);
                    b    = '0;
                    lane = 0;
                end
            end
            if (lane != 0) begin
                exp_w_q.push_back(b);
            end
        end
    endtask

    task automatic push_req(input user_req_t r);
        int   t;
        logic done;
        t         = 0;
        done      = 1'b0;
        req       = r;
        req_valid = 1'b1;
        while (!done && t < TIMEOUT) begin
            @(negedge ACLK);
            done = req_ready;
            @(posedge ACLK);
            #1;
            t++;
        end
        req_valid = 1'b0;
        if (!done) begin
            stop_on_timeout("request accept");
        end
    endtask

    task automatic push_word(input user_w_t d);
        int   t;
        logic done;
        t       = 0;
        done    = 1'b0;
        wdat    = d;
        w_valid = 1'b1;
        while (!done && t < TIMEOUT) begin
            @(negedge ACLK);
            done = w_ready;
            @(posedge ACLK);
            #1;
            t++;
        end
        w_valid = 1'b0;
        if (!done) begin
            stop_on_timeout("data word accept");
        end
    endtask

    task automatic send_all();
        fork
            while (req_list.size() > 0) push_req(req_list.pop_front());
            while (word_list.size() > 0) push_word(word_list.pop_front());
        join
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((cpl_seen < exp_cpl || exp_aw_q.size() > 0 || exp_w_q.size() > 0)
               && t < TIMEOUT) begin
            @(posedge ACLK);
            #1;
            t++;
        end
        if (t >= TIMEOUT) begin
            stop_on_timeout("bus traffic and completions");
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        $display("test %s done with %0d errors", name, errors - err0);
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic reset_idle();
        int err0;
        err0 = errors;
        check_flag("aw_valid", aw_valid, 1'b0);
        check_flag("w_valid_bus", w_valid_bus, 1'b0);
        check_flag("b_valid", b_valid, 1'b0);
        end_test("reset_idle", err0);
    endtask

    task automatic aligned_burst();
        int err0;
        err0 = errors;
        add_request(32'h40, 32'd4, 1'b1);
        send_all();
        wait_drain();
        check_cpl(cpl_seen, exp_cpl);
        end_test("aligned_burst", err0);
    endtask

    task automatic unaligned_burst();
        int err0;
        err0 = errors;
        add_request(32'h81, 32'd2, 1'b1);
        send_all();
        wait_drain();
        check_cpl(cpl_seen, exp_cpl);
        end_test("unaligned_burst", err0);
    endtask

    // completions behind a held bus response must wait for it
    task automatic invalid_lengths();
        int err0;
        int t;
        err0   = errors;
        t      = 0;
        hold_b = 1'b1;
        add_request(32'h10, 32'd0, 1'b1);
        add_request(32'h22, 32'd3, 1'b1);
        add_request(32'h30, 32'h8000_0002, 1'b1);
        send_all();
        while ((exp_w_q.size() > 0 || resp_owed == 0) && t < TIMEOUT) begin
            @(posedge ACLK);
            #1;
            t++;
        end
        if (t >= TIMEOUT) begin
            stop_on_timeout("beats of the held burst");
        end
        repeat (8) @(posedge ACLK);
        check_cpl(cpl_seen, exp_cpl - 2);
        hold_b = 1'b0;
        wait_drain();
        check_cpl(cpl_seen, exp_cpl);
        end_test("invalid_lengths", err0);
    endtask

    task automatic random_stream();
        int err0;
        int n;
        err0     = errors;
        stall_on = 1'b1;
        for (n = 0; n < 8; n++) begin
            add_request({$random(seed)} % 256, {$random(seed)} % 6, 1'b0);
        end
        send_all();
        wait_drain();
        check_cpl(cpl_seen, exp_cpl);
        stall_on = 1'b0;
        end_test("random_stream", err0);
    endtask

    initial begin
        req         = '0;
        req_valid   = 1'b0;
        wdat        = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b1;
        aw_ready    = 1'b1;
        w_ready_bus = 1'b1;
        b_valid_bus = 1'b0;
        ARESET      = 1'b1;
        repeat (16) @(posedge ACLK);
        #1;
        ARESET = 1'b0;
        reset_idle();
        aligned_burst();
        unaligned_burst();
        invalid_lengths();
        random_stream();
        errors += UUT.u_req_ctrl.aw_chk.fails + UUT.u_packer.w_chk.fails;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/store_bus_pkg.sv
design/store_user_pkg.sv
design/store_fifo.sv
design/store_req_ctrl.sv
design/store_beat_packer.sv
design/store_resp_tracker.sv
design/axi_store_top.sv
test/store_props.sv
test/tb_axi_store.sv
